// File: Makefile
TOP := tb_mem_system

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): files.f verilog/*.sv testbench/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: files.f
verilog/mem_pkg.sv
verilog/cache_way.sv
verilog/way_select.sv
verilog/cache_ctrl.sv
verilog/banked_mem.sv
verilog/mem_system.sv
testbench/tb_clock.sv
testbench/tb_mem_system.sv

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

endmodule

`default_nettype wire

// File: testbench/tb_mem_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_system;

	localparam int RESET_CYCLES = 16;
	localparam int NUM_RANDOM   = 64;
	localparam int NUM_REQS     = 21 + NUM_RANDOM;
	localparam int MISS_CYCLES  = 30;  // Write-back, fill with stalls, final and respond
	localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_REQS * MISS_CYCLES + 100;

	logic           clk;
	logic           rst;
	logic           rd;
	logic           wr;
	mem_pkg::addr_t addr;
	mem_pkg::word_t data_in;
	mem_pkg::word_t data_out;
	logic           done;
	logic           stall;
	logic           cache_hit;
	logic           err;

	// Reference model
	bit             ref_valid [mem_pkg::NUM_SETS][mem_pkg::NUM_WAYS];
	mem_pkg::tag_t  ref_tag   [mem_pkg::NUM_SETS][mem_pkg::NUM_WAYS];
	bit             ref_toggle;
	mem_pkg::word_t ref_data  [65536];
	bit             ref_written [65536];

	logic [15:0] lfsr = 16'd1424;
	int checks     = 0;
	int value_errs = 0;
	int proto_errs = 0;
	int miss_cnt   = 0;
	int cycle_cnt  = 0;

	tb_clock u_clock (.clk(clk));

	mem_system dut (
		.clk       (clk),
		.rst       (rst),
		.rd        (rd),
		.wr        (wr),
		.addr      (addr),
		.data_in   (data_in),
		.data_out  (data_out),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err)
	);

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	function automatic mem_pkg::addr_t word_addr(input mem_pkg::tag_t t,
			input mem_pkg::index_t idx, input mem_pkg::word_sel_t w);
		return {t, idx, w, 1'b0};
	endfunction

	task automatic check_word(input string name, input mem_pkg::word_t got,
			input mem_pkg::word_t exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	task automatic protocol_error(input string what);
		$display("Protocol error at %0t: %s", $time, what);
		proto_errs++;
	endtask

	// Predicts the hit and installs the line on a miss
	task automatic model_lookup(input mem_pkg::addr_t a, input logic bad, output logic hit);
		mem_pkg::tag_t   t;
		mem_pkg::index_t idx;
		int              way;
		t = a[15:11];
		idx = a[10:3];
		hit = 1'b0;
		if (!bad) begin
			for (int w = 0; w < mem_pkg::NUM_WAYS; w++)
				if (ref_valid[idx][w] && ref_tag[idx][w] == t)
					hit = 1'b1;
			if (!hit) begin
				if (!ref_valid[idx][0])
					way = 0;
				else if (!ref_valid[idx][1])
					way = 1;
				else
					way = int'(!ref_toggle);
				ref_valid[idx][way] = 1'b1;
				ref_tag[idx][way] = t;
			end
		end
		ref_toggle = !ref_toggle;  // Flips at every done including errors
	endtask

	task automatic run_access(input logic rd_i, input logic wr_i, input mem_pkg::addr_t a,
			input mem_pkg::word_t d);
		logic           exp_hit;
		logic           exp_err;
		logic           exp_read;
		mem_pkg::word_t exp_data;
		int             cycles;
		exp_err = a[0] || (rd_i && wr_i);
		exp_read = rd_i && !exp_err;
		exp_data = ref_data[a];
		model_lookup(a, exp_err, exp_hit);
		if (wr_i && !exp_err) begin
			ref_data[a] = d;
			ref_written[a] = 1'b1;
		end
		rd = rd_i;
		wr = wr_i;
		addr = a;
		data_in = d;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (!done && !stall)
				protocol_error("stall low while a request is pending");
		end while (!done);
		rd = 1'b0;  // No new request in the done cycle
		wr = 1'b0;
		if (stall)
			protocol_error("stall high together with done");
		check_flag("err", err, exp_err);
		check_flag("cache_hit", cache_hit, exp_hit);
		if (exp_read)
			check_word("data_out", data_out, exp_data);
		if (!cache_hit && !err)
			miss_cnt++;
		if ((exp_hit || exp_err) && cycles != 1)
			protocol_error($sformatf("hit or error answered after %0d cycles", cycles));
		if (!exp_hit && !exp_err && cycles < 2)
			protocol_error("miss answered as fast as a hit");
		@(negedge clk);
		if (done)
			protocol_error("done lasted more than one cycle");
	endtask

	task automatic write_then_read();
		mem_pkg::addr_t a;
		a = word_addr(5'd3, 8'd10, 2'd1);
		run_access(1'b0, 1'b1, a, 16'hbeef);  // Allocating miss
		run_access(1'b1, 1'b0, a, 16'h0000);
	endtask

	task automatic fill_whole_line();
		mem_pkg::addr_t a;
		for (int w = 0; w < mem_pkg::LINE_WORDS; w++) begin
			a = word_addr(5'd7, 8'd20, mem_pkg::word_sel_t'(w));
			run_access(1'b0, 1'b1, a, mem_pkg::word_t'(16'h1000 + w * 16'h0111));
		end
		for (int w = 0; w < mem_pkg::LINE_WORDS; w++) begin
			a = word_addr(5'd7, 8'd20, mem_pkg::word_sel_t'(w));
			run_access(1'b1, 1'b0, a, 16'h0000);
		end
	endtask

	// Third tag pushes a dirty line out
	task automatic evict_dirty_line();
		mem_pkg::addr_t a;
		int             misses_before;
		for (int t = 1; t <= 3; t++) begin
			a = word_addr(mem_pkg::tag_t'(t), 8'd33, 2'd2);
			run_access(1'b0, 1'b1, a, mem_pkg::word_t'(16'ha000 + t));
		end
		misses_before = miss_cnt;
		for (int t = 1; t <= 3; t++) begin
			a = word_addr(mem_pkg::tag_t'(t), 8'd33, 2'd2);
			run_access(1'b1, 1'b0, a, 16'h0000);
		end
		if (miss_cnt == misses_before)
			protocol_error("no re-read missed after three tags shared one set");
	endtask

	task automatic random_stream();
		logic [15:0]    r;
		logic [15:0]    op;
		logic [15:0]    d;
		mem_pkg::addr_t a;
		for (int n = 0; n < NUM_RANDOM; n++) begin
			rand_bits(6, r);
			// Four tags over four sets keeps both ways busy
			a = word_addr({3'b010, r[5:4]}, {6'd16, r[3:2]}, r[1:0]);
			rand_bits(1, op);
			rand_bits(16, d);
			if (!ref_written[a] || op[0])
				run_access(1'b0, 1'b1, a, d);
			else
				run_access(1'b1, 1'b0, a, 16'h0000);
		end
	endtask

	task automatic bad_requests();
		mem_pkg::addr_t a;
		a = word_addr(5'd9, 8'd50, 2'd2);
		run_access(1'b0, 1'b1, a, 16'h1234);
		run_access(1'b0, 1'b1, a | 16'h0001, 16'hdead);  // Odd address
		run_access(1'b1, 1'b1, a, 16'hdead);
		run_access(1'b1, 1'b0, a | 16'h0001, 16'h0000);
		run_access(1'b1, 1'b0, a, 16'h0000);  // Still the old value
	endtask

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("Timeout: the DUT gave no answer within %0d cycles", CYCLE_LIMIT);
			$display("Summary: %0d checks, %0d value errors, %0d protocol errors",
				checks, value_errs, proto_errs);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		rst = 1'b1;
		rd = 1'b0;
		wr = 1'b0;
		addr = '0;
		data_in = '0;
		ref_toggle = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		if (done || stall || cache_hit || err)
			protocol_error("response outputs not idle after reset");
		write_then_read();
		fill_whole_line();
		evict_dirty_line();
		random_stream();
		bad_requests();
		$display("Summary: %0d checks, %0d value errors, %0d protocol errors",
			checks, value_errs, proto_errs);
		if (value_errs + proto_errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/banked_mem.sv
`timescale 1ns/1ps
`default_nettype none

module banked_mem (
	input  logic                clk,
	input  logic                rst,
	input  mem_pkg::mem_req_t   req,
	output mem_pkg::mem_resp_t  resp
);

	mem_pkg::word_sel_t                   bank_sel;
	logic [12:0]                          row;
	logic [mem_pkg::NUM_BANKS-1:0]        bank_busy;
	mem_pkg::word_t                       bank_rdata [mem_pkg::NUM_BANKS];
	logic                                 access;
	logic                                 accept;
	mem_pkg::word_t                       rd_data_q  [mem_pkg::READ_LATENCY];
	logic [mem_pkg::READ_LATENCY-1:0]     rd_valid_q;

	// Low word address bits pick the bank
	assign bank_sel = req.addr[2:1];
	assign row      = req.addr[15:3];
	assign access   = req.rd || req.wr;
	assign accept   = access && !bank_busy[bank_sel];

	for (genvar b = 0; b < mem_pkg::NUM_BANKS; b++) begin : g_bank
		mem_pkg::word_t    bank_mem [mem_pkg::BANK_WORDS];
		mem_pkg::busy_cnt_t busy_cnt;
		logic              sel;

		assign sel = accept && (bank_sel == mem_pkg::word_sel_t'(b));

		always_ff @(posedge clk) begin
			if (rst)
				busy_cnt <= '0;
			else if (sel)
				busy_cnt <= mem_pkg::busy_cnt_t'(mem_pkg::BANK_BUSY_CYCLES);
			else if (busy_cnt != '0)
				busy_cnt <= busy_cnt - 1'b1;
		end

		always_ff @(posedge clk) begin
			if (sel && req.wr)
				bank_mem[row] <= req.wdata;
		end

		assign bank_busy[b]  = (busy_cnt != '0);
		assign bank_rdata[b] = bank_mem[row];
	end

	always_ff @(posedge clk) begin
		if (rst)
			rd_valid_q <= '0;
		else
			rd_valid_q <= {rd_valid_q[mem_pkg::READ_LATENCY-2:0], accept && req.rd};
	end

	// Read data travels alongside its valid bit
	always_ff @(posedge clk) begin
		rd_data_q[0] <= bank_rdata[bank_sel];
		for (int i = 1; i < mem_pkg::READ_LATENCY; i++)
			rd_data_q[i] <= rd_data_q[i-1];
	end

	always_comb begin
		resp.stall  = access && bank_busy[bank_sel];  // Same cycle refusal
		resp.rdata  = rd_data_q[mem_pkg::READ_LATENCY-1];
		resp.rvalid = rd_valid_q[mem_pkg::READ_LATENCY-1];
	end

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(req.rd && req.wr));

endmodule

`default_nettype wire

// File: verilog/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  logic                rd,
	input  logic                wr,
	input  mem_pkg::addr_t      addr,
	input  mem_pkg::word_t      data_in,
	output mem_pkg::way_req_t   way_req,
	input  mem_pkg::way_resp_t  way_resp,
	output mem_pkg::mem_req_t   mem_req,
	input  mem_pkg::mem_resp_t  mem_resp,
	output mem_pkg::word_t      data_out,
	output logic                done,
	output logic                stall,
	output logic                cache_hit,
	output logic                err
);

	mem_pkg::ctrl_state_t state, state_d;
	mem_pkg::tag_t        req_tag;
	mem_pkg::index_t      req_index;
	mem_pkg::word_sel_t   req_word;
	mem_pkg::word_sel_t   iss_cnt;      // Words sent to memory
	mem_pkg::word_sel_t   ret_cnt;      // Fill words installed
	mem_pkg::word_t       fill_data_q;
	logic                 fill_valid_q;
	logic                 req_valid;
	logic                 req_err;
	logic                 last_issue;

	assign req_tag    = addr[15:11];
	assign req_index  = addr[10:3];
	assign req_word   = addr[2:1];
	assign req_valid  = rd || wr;
	assign req_err    = addr[0] || (rd && wr);  // Odd address or both strobes
	assign last_issue = !mem_resp.stall &&
		(iss_cnt == mem_pkg::word_sel_t'(mem_pkg::LINE_WORDS - 1));

	assign stall = (state != mem_pkg::IDLE) && (state != mem_pkg::RESPOND);

	always_comb begin
		way_req = '0;
		way_req.index = req_index;
		way_req.tag = req_tag;
		way_req.word_sel = req_word;
		way_req.valid_in = 1'b1;
		case (state)
			mem_pkg::IDLE: begin
				way_req.comp  = 1'b1;
				way_req.write = wr && !req_err;
				way_req.pick  = req_valid && !req_err;
			end
			mem_pkg::WRITEBACK:
				way_req.word_sel = iss_cnt;  // Victim word going out
			mem_pkg::FILL_REQ, mem_pkg::FILL_WAIT: begin
				way_req.word_sel = ret_cnt;
				way_req.write = fill_valid_q;
			end
			mem_pkg::FINAL: begin
				way_req.comp  = 1'b1;
				way_req.write = wr;
			end
			default: ;
		endcase
		// Fill data on direct writes, requester data otherwise
		way_req.wdata = (way_req.write && !way_req.comp) ? fill_data_q : data_in;
	end

	always_comb begin
		mem_req = '0;
		mem_req.addr = {req_tag, req_index, iss_cnt, 1'b0};
		mem_req.wdata = way_resp.rdata;
		case (state)
			mem_pkg::WRITEBACK: begin
				mem_req.addr = {way_resp.tag, req_index, iss_cnt, 1'b0};
				mem_req.wr = 1'b1;
			end
			mem_pkg::FILL_REQ:
				mem_req.rd = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		state_d = state;
		case (state)
			mem_pkg::IDLE:
				if (req_valid) begin
					if (req_err || way_resp.hit)
						state_d = mem_pkg::RESPOND;
					else if (way_resp.valid && way_resp.dirty)
						state_d = mem_pkg::WRITEBACK;
					else
						state_d = mem_pkg::FILL_REQ;
				end
			mem_pkg::RESPOND:   state_d = mem_pkg::IDLE;
			mem_pkg::WRITEBACK: if (last_issue) state_d = mem_pkg::FILL_REQ;
			mem_pkg::FILL_REQ:  if (last_issue) state_d = mem_pkg::FILL_WAIT;
			mem_pkg::FILL_WAIT:
				if (fill_valid_q && ret_cnt == mem_pkg::word_sel_t'(mem_pkg::LINE_WORDS - 1))
					state_d = mem_pkg::FINAL;
			mem_pkg::FINAL:     state_d = mem_pkg::RESPOND;
			default:            state_d = mem_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= mem_pkg::IDLE;
			iss_cnt      <= '0;
			ret_cnt      <= '0;
			fill_valid_q <= 1'b0;
			done         <= 1'b0;
			cache_hit    <= 1'b0;
			err          <= 1'b0;
		end else begin
			state        <= state_d;
			fill_valid_q <= mem_resp.rvalid;
			done         <= 1'b0;
			cache_hit    <= 1'b0;
			err          <= 1'b0;
			if (state == mem_pkg::IDLE) begin
				iss_cnt <= '0;
				ret_cnt <= '0;
				if (req_valid && (req_err || way_resp.hit)) begin
					done      <= 1'b1;
					err       <= req_err;
					cache_hit <= !req_err;
				end
			end else begin
				if ((mem_req.rd || mem_req.wr) && !mem_resp.stall)
					iss_cnt <= iss_cnt + 2'd1;
				if (fill_valid_q)
					ret_cnt <= ret_cnt + 2'd1;
				if (state == mem_pkg::FINAL)
					done <= 1'b1;  // Miss finished, cache_hit stays low
			end
		end
	end

	always_ff @(posedge clk) begin
		fill_data_q <= mem_resp.rdata;
		if (state == mem_pkg::IDLE || state == mem_pkg::FINAL)
			data_out <= way_resp.rdata;
	end

	a_done_no_stall: assert property (@(posedge clk) disable iff (rst) !(done && stall));

endmodule

`default_nettype wire

// File: verilog/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way (
	input  logic                clk,
	input  logic                rst,
	input  mem_pkg::way_req_t   req,
	input  logic                we,
	output mem_pkg::way_resp_t  resp
);

	logic [mem_pkg::NUM_SETS-1:0] valid_q;
	logic [mem_pkg::NUM_SETS-1:0] dirty_q;
	mem_pkg::tag_t  tag_mem  [mem_pkg::NUM_SETS];
	mem_pkg::word_t data_mem [mem_pkg::NUM_SETS][mem_pkg::LINE_WORDS];
	logic tag_match;

	assign tag_match = (tag_mem[req.index] == req.tag);

	// Lookup is purely combinational on the set index
	always_comb begin
		resp.valid = valid_q[req.index];
		resp.dirty = dirty_q[req.index];
		resp.tag   = tag_mem[req.index];
		resp.rdata = data_mem[req.index][req.word_sel];
		resp.hit   = req.comp && valid_q[req.index] && tag_match;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (we) begin
			if (req.comp) begin
				dirty_q[req.index] <= 1'b1;  // Store from the requester
			end else begin
				valid_q[req.index] <= req.valid_in;
				dirty_q[req.index] <= 1'b0;  // Line now matches memory
			end
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			data_mem[req.index][req.word_sel] <= req.wdata;
			if (!req.comp) begin
				tag_mem[req.index] <= req.tag;
			end
		end
	end

	// Write enable is steered outside, the access type comes from the controller
	a_we_needs_write: assert property (@(posedge clk) disable iff (rst)
		we |-> req.write);

endmodule

`default_nettype wire

// File: verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [15:0] word_t;
	typedef logic [4:0]  tag_t;
	typedef logic [7:0]  index_t;
	typedef logic [1:0]  word_sel_t;  // Word in line, also the bank number

	localparam int NUM_WAYS         = 2;
	localparam int LINE_WORDS       = 4;
	localparam int NUM_SETS         = 256;
	localparam int NUM_BANKS        = 4;
	localparam int BANK_BUSY_CYCLES = 4;
	localparam int READ_LATENCY     = 2;
	localparam int BANK_WORDS       = 8192;  // 32K words spread over the banks
	localparam int BUSY_CNT_W       = $clog2(BANK_BUSY_CYCLES + 1);

	typedef logic [BUSY_CNT_W-1:0] busy_cnt_t;

	typedef struct packed {
		index_t    index;
		word_sel_t word_sel;
		tag_t      tag;
		word_t     wdata;
		logic      comp;      // Compare access when set
		logic      write;
		logic      valid_in;
		logic      pick;      // Lock the victim way
	} way_req_t;

	typedef struct packed {
		logic  hit;
		logic  valid;
		logic  dirty;
		tag_t  tag;
		word_t rdata;
	} way_resp_t;

	typedef struct packed {
		addr_t addr;
		word_t wdata;
		logic  wr;
		logic  rd;
	} mem_req_t;

	typedef struct packed {
		word_t rdata;
		logic  rvalid;
		logic  stall;
	} mem_resp_t;

	typedef enum logic [2:0] {
		IDLE,
		RESPOND,
		WRITEBACK,
		FILL_REQ,
		FILL_WAIT,
		FINAL
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: verilog/mem_system.sv
`timescale 1ns/1ps
`default_nettype none

module mem_system (
	input  logic            clk,
	input  logic            rst,
	input  logic            rd,
	input  logic            wr,
	input  mem_pkg::addr_t  addr,
	input  mem_pkg::word_t  data_in,
	output mem_pkg::word_t  data_out,
	output logic            done,
	output logic            stall,
	output logic            cache_hit,
	output logic            err
);

	mem_pkg::way_req_t                way_req;
	mem_pkg::way_resp_t               way_resps [mem_pkg::NUM_WAYS];
	mem_pkg::way_resp_t               way_resp;     // Merged view for the FSM
	logic [mem_pkg::NUM_WAYS-1:0]     way_we;
	mem_pkg::mem_req_t                mem_req;
	mem_pkg::mem_resp_t               mem_resp;

	cache_ctrl u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.rd        (rd),
		.wr        (wr),
		.addr      (addr),
		.data_in   (data_in),
		.way_req   (way_req),
		.way_resp  (way_resp),
		.mem_req   (mem_req),
		.mem_resp  (mem_resp),
		.data_out  (data_out),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err)
	);

	// Every way sees the same request, only its write enable differs
	for (genvar i = 0; i < mem_pkg::NUM_WAYS; i++) begin : g_way
		cache_way u_way (
			.clk  (clk),
			.rst  (rst),
			.req  (way_req),
			.we   (way_we[i]),
			.resp (way_resps[i])
		);
	end

	way_select u_sel (
		.clk    (clk),
		.rst    (rst),
		.resps  (way_resps),
		.req    (way_req),
		.done   (done),
		.way_we (way_we),
		.resp   (way_resp)
	);

	banked_mem u_mem (
		.clk  (clk),
		.rst  (rst),
		.req  (mem_req),
		.resp (mem_resp)
	);

endmodule

`default_nettype wire

// File: verilog/way_select.sv
`timescale 1ns/1ps
`default_nettype none

module way_select (
	input  logic                                  clk,
	input  logic                                  rst,
	input  mem_pkg::way_resp_t                    resps [mem_pkg::NUM_WAYS],
	input  mem_pkg::way_req_t                     req,
	input  logic                                  done,
	output logic [mem_pkg::NUM_WAYS-1:0]          way_we,
	output mem_pkg::way_resp_t                    resp
);

	logic                          toggle;
	logic                          victim_q;
	logic                          victim_next;
	logic                          hit_way;
	logic                          active;
	logic [mem_pkg::NUM_WAYS-1:0]  hits;

	// Invalid way first, way 0 when both are free
	always_comb begin
		if (!resps[0].valid)
			victim_next = 1'b0;
		else if (!resps[1].valid)
			victim_next = 1'b1;
		else
			victim_next = ~toggle;
	end

	always_comb begin
		hit_way = 1'b0;
		for (int i = 0; i < mem_pkg::NUM_WAYS; i++) begin
			hits[i] = resps[i].hit;
			if (resps[i].hit)
				hit_way = 1'(i);
		end
		// Victim not yet locked in the pick cycle
		active = (|hits) ? hit_way : (req.pick ? victim_next : victim_q);
		resp = resps[active];
		resp.hit = |hits;
		for (int i = 0; i < mem_pkg::NUM_WAYS; i++)
			way_we[i] = req.write && (req.comp ? hits[i] : (victim_q == 1'(i)));
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			toggle   <= 1'b0;
			victim_q <= 1'b0;
		end else begin
			if (done)
				toggle <= ~toggle;
			if (req.pick)
				victim_q <= victim_next;
		end
	end

	a_one_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(hits));

endmodule

`default_nettype wire
